// ==== filelist.f ====
design/opn_timing_pkg.sv
design/opn_regmap_pkg.sv
design/clk_prescaler.sv
design/bus_write_port.sv
design/global_ctrl_regs.sv
design/ch3_freq_regs.sv
design/update_decoder.sv
design/fm_regs_top.sv
test/fm_regs_props.sv
test/tb_fm_regs.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_fm_regs
FILELIST  := filelist.f
VFLAGS    := --binary --assert -j 0 --top-module $(TOP)
BUILD_DIR := obj_dir

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_fm_regs.sv ====
`timescale 1ns/1ps

module tb_fm_regs import opn_regmap_pkg::*; ();

    logic       clk = 1'b0;
    logic       rst;
    logic       cen;
    logic [7:0] din;
    logic       write;
    logic [1:0] addr;

    logic                 clk_en, busy, eg_stop, pg_stop, fast_timers, lfo_en;
    logic                 load_a, load_b, enable_irq_a, enable_irq_b, clr_flag_a, clr_flag_b;
    logic                 csm, effect, pcm_en, pcm_wr, up_keyon;
    logic [2:0]           lfo_freq, up_ch;
    logic [1:0]           up_op;
    logic [TIMER_A_W-1:0] value_a;
    logic [TIMER_B_W-1:0] value_b;
    logic [PCM_W-1:0]     pcm;
    logic [FNUM_W-1:0]    fnum_ch3op1, fnum_ch3op2, fnum_ch3op3;
    logic [BLOCK_W-1:0]   block_ch3op1, block_ch3op2, block_ch3op3;
    reg_group_e           up_group;

    integer seed = 59;

    fm_regs_top DUT (.*);

    bind fm_regs_top fm_regs_props u_props (.*);

    always #4 clk = ~clk;

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // Address phase then data phase, result visible at the closing negedge
    task automatic bus_write(input reg_addr_t reg_a, input logic [7:0] data, input logic bank);
        @(posedge clk);
        write <= 1'b1;
        addr  <= {bank, 1'b0};
        din   <= reg_a;
        @(posedge clk);
        write <= 1'b0;
        @(posedge clk);
        write <= 1'b1;
        addr  <= {bank, 1'b1};
        din   <= data;
        @(posedge clk);
        write <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_clk_en;
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 50)
                fail_now("timeout while waiting for a clk_en pulse");
        end while (!clk_en);
    endtask

    task automatic measure_gap(output int gap);
        wait_clk_en();
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
            if (gap > 50)
                fail_now("timeout while measuring the clk_en spacing");
        end while (!clk_en);
    endtask

    // Group from the register map table
    function automatic reg_group_e expected_group(input reg_addr_t a);
        if (a[1:0] == 2'b11)
            return GRP_NONE;
        if (a[7:4] >= 4'h3 && a[7:4] <= 4'h9)
            return reg_group_e'(a[7:4] + 4'd1);    // DT1 follows PMS
        if (a[7:4] == 4'hA && a[3:2] == 2'b00)
            return GRP_FNUM_LO;
        if (a[7:4] == 4'hB && a[3:2] == 2'b00)
            return GRP_ALG;
        if (a[7:4] == 4'hB && a[3:2] == 2'b01)
            return GRP_PMS;
        return GRP_NONE;
    endfunction

    task automatic reset_values;
        int gap;
        check("busy", 32'(busy), 0);
        check("pcm_wr", 32'(pcm_wr), 0);
        check("clr_flags", 32'({clr_flag_b, clr_flag_a}), 0);
        check("load_irq", 32'({load_b, load_a, enable_irq_b, enable_irq_a}), 0);
        check("csm_effect", 32'({csm, effect}), 0);
        check("test_bits", 32'({eg_stop, pg_stop, fast_timers}), 0);
        check("values", {value_a, value_b, pcm, pcm_en, lfo_en, lfo_freq}, 0);
        check("ch3_op1", 32'({block_ch3op1, fnum_ch3op1}), 0);
        check("ch3_op2", 32'({block_ch3op2, fnum_ch3op2}), 0);
        check("ch3_op3", 32'({block_ch3op3, fnum_ch3op3}), 0);
        check("up_group", 32'(up_group), 32'(GRP_NONE));
        check("up_fields", 32'({up_keyon, up_ch, up_op}), 0);
        repeat (2) begin
            measure_gap(gap);
            check("clk_en_gap", gap, 6);
        end
    endtask

    task automatic global_regs;
        reg_addr_t  glob_regs [6] = '{REG_TESTYM, REG_LFO, REG_CLKA1,
                                      REG_CLKA2, REG_CLKB, REG_TIMER};
        logic [7:0] tst, lfo, a_hi, a_lo, b_val, ctl;
        tst   = 8'($random(seed));
        lfo   = 8'($random(seed));
        a_hi  = 8'($random(seed));
        a_lo  = 8'($random(seed));
        b_val = 8'($random(seed));
        ctl   = 8'($random(seed));
        ctl[5:4] = 2'b11;   // Fire both flag clears
        foreach (glob_regs[i])
            bus_write(glob_regs[i], (i == 0) ? tst : (i == 1) ? lfo : (i == 2) ? a_hi :
                      (i == 3) ? a_lo : (i == 4) ? b_val : ctl, 1'b0);
        check("clr_flags", 32'({clr_flag_b, clr_flag_a}), 32'(2'b11));
        wait_clk_en();
        @(negedge clk);
        check("clr_flags", 32'({clr_flag_b, clr_flag_a}), 0);
        // Bank 1 copies must leave everything alone
        for (int pass = 0; pass < 2; pass++) begin
            check("test_bits", 32'({eg_stop, pg_stop, fast_timers}),
                  32'({tst[5], tst[3], tst[2]}));
            check("lfo", 32'({lfo_en, lfo_freq}), 32'(lfo[3:0]));
            check("value_a", 32'(value_a), 32'({a_hi, a_lo[1:0]}));
            check("value_b", 32'(value_b), 32'(b_val));
            check("effect", 32'(effect), 32'(|ctl[7:6]));
            check("csm", 32'(csm), 32'(ctl[7:6] == 2'b10));
            check("timer_ctl", 32'({enable_irq_b, enable_irq_a, load_b, load_a}),
                  32'(ctl[3:0]));
            if (pass == 0) begin
                foreach (glob_regs[i])
                    bus_write(glob_regs[i], 8'($random(seed)) | 8'h30, 1'b1);  // Flag bits set
            end
        end
        check("clr_flags", 32'({clr_flag_b, clr_flag_a}), 0);
    endtask

    task automatic dac_regs;
        logic [7:0] d;
        logic [8:0] exp_pcm;
        d = 8'($random(seed));
        bus_write(REG_PCM, d, 1'b0);
        exp_pcm = {~d[7], d[6:0], 1'b1};
        check("pcm", 32'(pcm), 32'(exp_pcm));
        check("pcm_wr", 32'(pcm_wr), 1);
        wait_clk_en();
        @(negedge clk);
        check("pcm_wr", 32'(pcm_wr), 0);
        d = 8'($random(seed));
        bus_write(REG_DACTEST, d, 1'b0);
        exp_pcm[0] = d[3];
        check("pcm", 32'(pcm), 32'(exp_pcm));
        bus_write(REG_PCM_EN, 8'h80, 1'b0);
        check("pcm_en", 32'(pcm_en), 1);
        bus_write(REG_PCM_EN, 8'h7F, 1'b0);
        check("pcm_en", 32'(pcm_en), 0);
    endtask

    task automatic ch3_freqs;
        reg_addr_t   ops [3]      = '{REG_CH3_OP1, REG_CH3_OP3, REG_CH3_OP2};
        reg_addr_t   lat_regs [3] = '{8'hA6, 8'hAC, 8'hA5};
        int          slot [3]     = '{0, 2, 1};
        logic [13:0] exp_op [3]   = '{default: '0};   // Block and fnum of op1..op3
        logic [7:0]  lat, lo;
        foreach (ops[i]) begin
            lat = 8'($random(seed));
            lo  = 8'($random(seed));
            bus_write(lat_regs[i], lat, 1'($random(seed)));
            bus_write(ops[i], lo, 1'b0);
            exp_op[slot[i]] = {lat[5:0], lo};
            check("ch3_op1", 32'({block_ch3op1, fnum_ch3op1}), 32'(exp_op[0]));
            check("ch3_op2", 32'({block_ch3op2, fnum_ch3op2}), 32'(exp_op[1]));
            check("ch3_op3", 32'({block_ch3op3, fnum_ch3op3}), 32'(exp_op[2]));
        end
    endtask

    task automatic prescaler_busy;
        int gap;
        int pulses;
        int n;
        bus_write(REG_CLK_N2, 8'h00, 1'b0);
        measure_gap(gap);
        check("clk_en_gap", gap, 2);
        bus_write(REG_CLK_N3, 8'h00, 1'b0);
        check("busy", 32'(busy), 1);
        pulses = 0;
        n = 0;
        while (busy) begin
            if (clk_en)
                pulses++;
            @(negedge clk);
            n++;
            if (n > 400)
                fail_now("timeout while waiting for busy to fall");
        end
        check("busy_clk_en_pulses", pulses, 32);
        measure_gap(gap);
        check("clk_en_gap", gap, 3);
    endtask

    task automatic decoder_groups;
        reg_addr_t a;
        logic      bank;
        for (int i = 0; i < 40; i++) begin
            a    = {4'(2 + ($unsigned($random(seed)) % 10)), 4'($random(seed))};
            bank = 1'($random(seed));
            if (i == 0) begin
                a    = REG_KON;     // Key-on hit at least once
                bank = 1'b0;
            end
            bus_write(a, 8'h00, bank);
            check("up_group", 32'(up_group), 32'(expected_group(a)));
            check("up_ch", 32'(up_ch), 32'({bank, a[1:0]}));
            check("up_op", 32'(up_op), 32'(a[3:2]));
            check("up_keyon", 32'(up_keyon), 32'(a == REG_KON && !bank));
        end
    endtask

    initial begin
        rst   <= 1'b1;
        cen   <= 1'b1;
        din   <= 8'h00;
        write <= 1'b0;
        addr  <= 2'b00;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        reset_values();
        global_regs();
        dac_regs();
        ch3_freqs();
        prescaler_busy();
        decoder_groups();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== test/fm_regs_props.sv ====
`timescale 1ns/1ps

module fm_regs_props (
    input logic       clk,
    input logic       rst,
    input logic       write,
    input logic [1:0] addr,
    input logic       clk_en,
    input logic       busy,
    input logic       pcm_wr,
    input logic       clr_flag_a,
    input logic       clr_flag_b
);

    // Fresh data write starts the busy period
    property busy_after_data_edge;
        @(posedge clk) disable iff (rst)
            (write && addr[0] && !$past(write)) |=> busy;
    endproperty

    property pcm_wr_ends_on_clk_en;
        @(posedge clk) disable iff (rst)
            (clk_en && !(write && addr[0])) |=> !pcm_wr;
    endproperty

    property clr_flags_end_on_clk_en;
        @(posedge clk) disable iff (rst)
            (clk_en && !(write && addr[0])) |=> !clr_flag_a && !clr_flag_b;
    endproperty

    a_busy: assert property (busy_after_data_edge)
        else $error("busy low one cycle after a data write edge");

    a_pcm_wr: assert property (pcm_wr_ends_on_clk_en)
        else $error("pcm_wr still high after clk_en without a data write");

    a_clr_flags: assert property (clr_flags_end_on_clk_en)
        else $error("timer flag clear still high after clk_en");

endmodule

// ==== design/fm_regs_top.sv ====
`timescale 1ns/1ps

module fm_regs_top import opn_timing_pkg::*, opn_regmap_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  logic [7:0]           din,
    input  logic                 write,
    input  logic [1:0]           addr,
    output logic                 clk_en,
    output logic                 busy,
    output logic                 eg_stop,
    output logic                 pg_stop,
    output logic                 fast_timers,
    output logic                 lfo_en,
    output logic [2:0]           lfo_freq,
    output logic [TIMER_A_W-1:0] value_a,
    output logic [TIMER_B_W-1:0] value_b,
    output logic                 load_a,
    output logic                 load_b,
    output logic                 enable_irq_a,
    output logic                 enable_irq_b,
    output logic                 clr_flag_a,
    output logic                 clr_flag_b,
    output logic                 csm,
    output logic                 effect,
    output logic [PCM_W-1:0]     pcm,
    output logic                 pcm_en,
    output logic                 pcm_wr,
    output logic [FNUM_W-1:0]    fnum_ch3op1,
    output logic [FNUM_W-1:0]    fnum_ch3op2,
    output logic [FNUM_W-1:0]    fnum_ch3op3,
    output logic [BLOCK_W-1:0]   block_ch3op1,
    output logic [BLOCK_W-1:0]   block_ch3op2,
    output logic [BLOCK_W-1:0]   block_ch3op3,
    output logic                 up_keyon,
    output logic [2:0]           up_ch,
    output logic [1:0]           up_op,
    output reg_group_e           up_group
);

    reg_addr_t  sel_reg;
    logic       part;
    logic       data_wr;
    logic [7:0] wr_data;
    div_mode_e  div_mode;

    clk_prescaler u_prescaler (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .div_mode (div_mode),
        .clk_en   (clk_en)
    );

    bus_write_port u_bus (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .din     (din),
        .write   (write),
        .addr    (addr),
        .sel_reg (sel_reg),
        .part    (part),
        .data_wr (data_wr),
        .wr_data (wr_data),
        .busy    (busy)
    );

    global_ctrl_regs u_global (.*);

    ch3_freq_regs u_ch3 (.*);

    update_decoder u_decoder (.*);

endmodule

// ==== design/update_decoder.sv ====
`timescale 1ns/1ps

module update_decoder import opn_regmap_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  reg_addr_t  sel_reg,
    input  logic       part,
    input  logic       data_wr,
    output logic       up_keyon,
    output logic [2:0] up_ch,
    output logic [1:0] up_op,
    output reg_group_e up_group
);

    reg_group_e grp;

    always_comb begin
        if (sel_reg[1:0] == 2'b11) begin
            grp = GRP_NONE;     // No fourth channel in a bank
        end else begin
            casez (sel_reg)
                8'hA0, 8'hA1, 8'hA2: grp = GRP_FNUM_LO;
                8'hB0, 8'hB1, 8'hB2: grp = GRP_ALG;
                8'hB4, 8'hB5, 8'hB6: grp = GRP_PMS;
                8'h3?:   grp = GRP_DT1;
                8'h4?:   grp = GRP_TL;
                8'h5?:   grp = GRP_KS_AR;
                8'h6?:   grp = GRP_AMEN_DR;
                8'h7?:   grp = GRP_SR;
                8'h8?:   grp = GRP_SL_RR;
                8'h9?:   grp = GRP_SSGEG;
                default: grp = GRP_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            up_keyon <= 1'b0;
            up_ch    <= '0;
            up_op    <= '0;
            up_group <= GRP_NONE;
        end else if (data_wr) begin
            up_keyon <= (sel_reg == REG_KON) && !part;
            up_ch    <= {part, sel_reg[1:0]};
            up_op    <= sel_reg[3:2];   // Slot order S1 S3 S2 S4
            up_group <= grp;
        end
    end

endmodule

// ==== design/ch3_freq_regs.sv ====
`timescale 1ns/1ps

module ch3_freq_regs import opn_regmap_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  reg_addr_t          sel_reg,
    input  logic               data_wr,
    input  logic [7:0]         wr_data,
    output logic [FNUM_W-1:0]  fnum_ch3op1,
    output logic [FNUM_W-1:0]  fnum_ch3op2,
    output logic [FNUM_W-1:0]  fnum_ch3op3,
    output logic [BLOCK_W-1:0] block_ch3op1,
    output logic [BLOCK_W-1:0] block_ch3op2,
    output logic [BLOCK_W-1:0] block_ch3op3
);

    // One latch shared by every channel's fnum high write
    logic [LATCH_W-1:0] latch_fnum;

    always_ff @(posedge clk) begin
        if (rst) begin
            latch_fnum   <= '0;
            fnum_ch3op1  <= '0;
            fnum_ch3op2  <= '0;
            fnum_ch3op3  <= '0;
            block_ch3op1 <= '0;
            block_ch3op2 <= '0;
            block_ch3op3 <= '0;
        end else if (data_wr) begin
            case (sel_reg)
                REG_CH3_OP1: {block_ch3op1, fnum_ch3op1} <= {latch_fnum, wr_data};
                REG_CH3_OP3: {block_ch3op3, fnum_ch3op3} <= {latch_fnum, wr_data};
                REG_CH3_OP2: {block_ch3op2, fnum_ch3op2} <= {latch_fnum, wr_data};
                8'hA4, 8'hA5, 8'hA6,
                8'hAC, 8'hAD, 8'hAE: latch_fnum <= wr_data[LATCH_W-1:0];
                default: ;
            endcase
        end
    end

endmodule

// ==== design/global_ctrl_regs.sv ====
`timescale 1ns/1ps

module global_ctrl_regs import opn_timing_pkg::*, opn_regmap_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clk_en,
    input  reg_addr_t            sel_reg,
    input  logic                 part,
    input  logic                 data_wr,
    input  logic [7:0]           wr_data,
    output div_mode_e            div_mode,
    output logic                 eg_stop,
    output logic                 pg_stop,
    output logic                 fast_timers,
    output logic                 lfo_en,
    output logic [2:0]           lfo_freq,
    output logic [TIMER_A_W-1:0] value_a,
    output logic [TIMER_B_W-1:0] value_b,
    output logic                 load_a,
    output logic                 load_b,
    output logic                 enable_irq_a,
    output logic                 enable_irq_b,
    output logic                 clr_flag_a,
    output logic                 clr_flag_b,
    output logic                 csm,
    output logic                 effect,
    output logic [PCM_W-1:0]     pcm,
    output logic                 pcm_en,
    output logic                 pcm_wr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            div_mode     <= DIV_RESET;
            eg_stop      <= 1'b0;
            pg_stop      <= 1'b0;
            fast_timers  <= 1'b0;
            lfo_en       <= 1'b0;
            lfo_freq     <= '0;
            value_a      <= '0;
            value_b      <= '0;
            load_a       <= 1'b0;
            load_b       <= 1'b0;
            enable_irq_a <= 1'b0;
            enable_irq_b <= 1'b0;
            clr_flag_a   <= 1'b0;
            clr_flag_b   <= 1'b0;
            csm          <= 1'b0;
            effect       <= 1'b0;
            pcm          <= '0;
            pcm_en       <= 1'b0;
            pcm_wr       <= 1'b0;
        end else if (data_wr) begin
            // Global control lives in bank 0 only
            if (!part) begin
                case (sel_reg)
                    REG_TESTYM: begin
                        eg_stop     <= wr_data[5];
                        pg_stop     <= wr_data[3];
                        fast_timers <= wr_data[2];
                    end
                    REG_LFO:   {lfo_en, lfo_freq} <= wr_data[3:0];
                    REG_CLKA1: value_a[9:2] <= wr_data;         // Timer A high part
                    REG_CLKA2: value_a[1:0] <= wr_data[1:0];
                    REG_CLKB:  value_b <= wr_data;
                    REG_TIMER: begin
                        effect <= |wr_data[7:6];
                        csm    <= wr_data[7:6] == 2'b10;
                        {clr_flag_b, clr_flag_a} <= wr_data[5:4];
                        {enable_irq_b, enable_irq_a} <= wr_data[3:2];
                        {load_b, load_a} <= wr_data[1:0];
                    end
                    // Prescaler, writes set or clear mode bits
                    REG_CLK_N6: div_mode <= div_mode_e'({1'b1, div_mode[0]});
                    REG_CLK_N3: div_mode <= div_mode_e'({div_mode[1], 1'b1});
                    REG_CLK_N2: div_mode <= DIV_2;
                    default: ;
                endcase
            end

            // DAC registers
            case (sel_reg)
                REG_PCM:     pcm <= {~wr_data[7], wr_data[6:0], 1'b1};  // Offset binary
                REG_DACTEST: pcm[0] <= wr_data[3];
                REG_PCM_EN:  pcm_en <= wr_data[7];
                default: ;
            endcase
            pcm_wr <= sel_reg == REG_PCM;
        end else if (clk_en) begin
            // One-shot bits end at the next synthesis enable
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            pcm_wr     <= 1'b0;
        end
    end

endmodule

// ==== design/bus_write_port.sv ====
`timescale 1ns/1ps

module bus_write_port import opn_timing_pkg::*, opn_regmap_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       clk_en,
    input  logic [7:0] din,
    input  logic       write,
    input  logic [1:0] addr,
    output reg_addr_t  sel_reg,
    output logic       part,
    output logic       data_wr,
    output logic [7:0] wr_data,
    output logic       busy
);

    logic                  write_q;
    logic [BUSY_CNT_W-1:0] busy_cnt;
    logic                  data_edge;

    // Data phase of the bus
    assign data_wr = write && addr[0];
    assign wr_data = din;

    // Only a fresh data write starts the busy period
    assign data_edge = !write_q && write && addr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg <= '0;
            part    <= 1'b0;
        end else if (write && !addr[0]) begin
            sel_reg <= din;
            part    <= addr[1];     // Bank select
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            write_q <= 1'b0;
        else
            write_q <= write;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_edge) begin
            busy     <= 1'b1;
            busy_cnt <= '0;
        end else if (clk_en) begin
            if (busy_cnt == BUSY_CNT_W'(BUSY_LEN - 1))
                busy <= 1'b0;
            busy_cnt <= busy_cnt + 1'b1;    // Wraps after 32
        end
    end

endmodule

// ==== design/clk_prescaler.sv ====
`timescale 1ns/1ps

module clk_prescaler import opn_timing_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    input  div_mode_e div_mode,
    output logic      clk_en
);

    logic [DIV_CNT_W-1:0] cnt;
    logic [DIV_CNT_W-1:0] last;
    div_mode_e            mode_q;   // Mode seen on the previous cycle

    always_comb begin
        case (div_mode)
            DIV_2:         last = DIV_CNT_W'(1);
            DIV_3, DIV_3B: last = DIV_CNT_W'(2);
            default:       last = DIV_CNT_W'(5);
        endcase
    end

    // No pulse on the cycle the mode switches
    assign clk_en = cen && (cnt == last) && (div_mode == mode_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            mode_q <= DIV_RESET;
        end else begin
            mode_q <= div_mode;
            if (div_mode != mode_q)
                cnt <= '0;  // Restart on a new division
            else if (cen)
                cnt <= (cnt == last) ? '0 : cnt + 1'b1;
        end
    end

endmodule

// ==== design/opn_regmap_pkg.sv ====
package opn_regmap_pkg;

    typedef logic [7:0] reg_addr_t;

    // Global registers, bank 0
    localparam reg_addr_t REG_TESTYM  = 8'h21;
    localparam reg_addr_t REG_LFO     = 8'h22;
    localparam reg_addr_t REG_CLKA1   = 8'h24;
    localparam reg_addr_t REG_CLKA2   = 8'h25;
    localparam reg_addr_t REG_CLKB    = 8'h26;
    localparam reg_addr_t REG_TIMER   = 8'h27;
    localparam reg_addr_t REG_KON     = 8'h28;
    localparam reg_addr_t REG_PCM     = 8'h2A;
    localparam reg_addr_t REG_PCM_EN  = 8'h2B;
    localparam reg_addr_t REG_DACTEST = 8'h2C;
    localparam reg_addr_t REG_CLK_N6  = 8'h2D;
    localparam reg_addr_t REG_CLK_N3  = 8'h2E;
    localparam reg_addr_t REG_CLK_N2  = 8'h2F;

    // Channel 3 special mode frequencies
    localparam reg_addr_t REG_CH3_OP1 = 8'hA9;
    localparam reg_addr_t REG_CH3_OP3 = 8'hA8;
    localparam reg_addr_t REG_CH3_OP2 = 8'hAA;

    // Field widths
    localparam int FNUM_W    = 11;
    localparam int BLOCK_W   = 3;
    localparam int LATCH_W   = 6;   // block plus fnum high bits
    localparam int TIMER_A_W = 10;
    localparam int TIMER_B_W = 8;
    localparam int PCM_W     = 9;

    // Register group hit by the last data write
    typedef enum logic [3:0] {
        GRP_NONE,
        GRP_FNUM_LO,    // A0-A2
        GRP_ALG,        // B0-B2, feedback and algorithm
        GRP_PMS,        // B4-B6
        GRP_DT1,        // 3x
        GRP_TL,         // 4x
        GRP_KS_AR,      // 5x
        GRP_AMEN_DR,    // 6x
        GRP_SR,         // 7x
        GRP_SL_RR,      // 8x
        GRP_SSGEG       // 9x
    } reg_group_e;

endpackage

// ==== design/opn_timing_pkg.sv ====
package opn_timing_pkg;

    // Prescaler setting, 01 and 10 both divide by 3
    typedef enum logic [1:0] {
        DIV_2  = 2'b00,
        DIV_3  = 2'b01,
        DIV_3B = 2'b10,
        DIV_6  = 2'b11
    } div_mode_e;

    localparam div_mode_e DIV_RESET = DIV_6;

    // Prescaler counter, wide enough for the divide-by-6 setting
    localparam int DIV_CNT_W = 3;

    // Busy flag length in synthesis clock enables
    localparam int BUSY_LEN   = 32;
    localparam int BUSY_CNT_W = 5;

endpackage
